// ==== Makefile ====
TOP = mandel_render_tb

.PHONY: lint sim clean

# lint the design top with the bound checks
lint:
	verilator --lint-only --timing --assert -Wall -f vlog.f --top-module mandel_render_top

# pass only if the run prints TEST PASS
sim:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) +verilator+error+limit+100 | tee /dev/stderr | grep "TEST PASS" > /dev/null

clean:
	rm -rf obj_dir

// ==== source/escape_solver.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mandel_defs.svh"

module escape_solver #(
	parameter int unsigned MAX_ITER = `MAX_ITER_DEFAULT
) (
	input  wire logic                 iCLK,
	input  wire logic                 arst_n,
	input  wire logic                 solve_start,
	input  wire fixed_math_pkg::fix_t c_re,
	input  wire fixed_math_pkg::fix_t c_im,
	output fixed_math_pkg::iter_t     iter_count,
	output logic                      solve_done
);

	// z and c working registers
	fixed_math_pkg::fix_t zr, zi;
	fixed_math_pkg::fix_t cr_q, ci_q;
	logic busy;

	// ==================================================
	// one iteration, combinational
	// ==================================================
	fixed_math_pkg::prod_t zr_sq, zi_sq, zr_zi, mag;
	fixed_math_pkg::fix_t  zr_next, zi_next;
	logic escaped, at_limit, stop;

	// full products, rescaled with truncation
	assign zr_sq = (fixed_math_pkg::prod_t'(zr) * fixed_math_pkg::prod_t'(zr)) >>> `FIX_FRAC;
	assign zi_sq = (fixed_math_pkg::prod_t'(zi) * fixed_math_pkg::prod_t'(zi)) >>> `FIX_FRAC;
	assign zr_zi = (fixed_math_pkg::prod_t'(zr) * fixed_math_pkg::prod_t'(zi)) >>> `FIX_FRAC;

	// |z|^2 kept wide so it cannot wrap below the limit
	assign mag      = zr_sq + zi_sq;
	assign escaped  = mag >= fixed_math_pkg::prod_t'(`ESCAPE_LIMIT);
	assign at_limit = iter_count == fixed_math_pkg::iter_t'(MAX_ITER);
	assign stop     = escaped | at_limit;

	// z^2 + c, doubling applied after the rescale
	assign zr_next = fixed_math_pkg::fix_t'(zr_sq - zi_sq) + cr_q;
	assign zi_next = fixed_math_pkg::fix_t'(zr_zi <<< 1) + ci_q;

	// done in the busy cycle that finds the stop condition
	assign solve_done = busy & stop;

	// ==================================================
	// control: busy flag and count
	// ==================================================
	always_ff @(posedge iCLK or negedge arst_n) begin
		if (!arst_n) begin
			busy       <= 1'b0;
			iter_count <= '0;
		end else if (solve_start) begin
			busy       <= 1'b1;
			iter_count <= '0;
		end else if (busy) begin
			if (stop)
				busy <= 1'b0;
			else
				iter_count <= iter_count + fixed_math_pkg::iter_t'(1);
		end
	end

	// datapath, loaded on start then stepped
	always_ff @(posedge iCLK) begin
		if (solve_start) begin
			cr_q <= c_re;
			ci_q <= c_im;
			zr   <= '0;
			zi   <= '0;
		end else if (busy && !stop) begin
			zr <= zr_next;
			zi <= zi_next;
		end
	end

endmodule

`default_nettype wire

// ==== source/fixed_math_pkg.sv ====
`default_nettype none

`include "mandel_defs.svh"

package fixed_math_pkg;

	// ==================================================
	// arithmetic types
	// ==================================================

	// signed 4.23 value
	typedef logic signed [`FIX_W-1:0] fix_t;

	// full product of two fix_t, before rescaling
	typedef logic signed [2*`FIX_W-1:0] prod_t;

	// escape-time count
	typedef logic [`ITER_W-1:0] iter_t;

endpackage

`default_nettype wire

// ==== source/frame_bus_pkg.sv ====
`default_nettype none

`include "mandel_defs.svh"

package frame_bus_pkg;

	// ==================================================
	// frame buffer side
	// ==================================================

	// pixel column or row
	typedef logic [`COORD_W-1:0] coord_t;

	// word address on the video memory bus
	typedef logic [31:0] bus_addr_t;

	// 8-bit palette colour
	typedef logic [7:0] color_t;

	// pixel scan FSM
	typedef enum logic [2:0] {
		IDLE_INIT,
		SOLVE_START,
		SOLVE_WAIT,
		WRITE,
		WRITE_ACK,
		PAUSE,
		FRAME_IDLE
	} scan_state_t;

endpackage

`default_nettype wire

// ==== source/frame_scanner.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mandel_defs.svh"

module frame_scanner #(
	parameter int                      H_RES     = `H_RES_DEFAULT,
	parameter int                      V_RES     = `V_RES_DEFAULT,
	parameter frame_bus_pkg::bus_addr_t VRAM_BASE = 32'h0000_0000
) (
	input  wire logic                  iCLK,
	input  wire logic                  arst_n,
	input  wire logic [3:0]            pause_len,
	input  wire logic                  solve_done,
	input  wire frame_bus_pkg::color_t pixel_color,
	input  wire logic                  bus_ack,
	output frame_bus_pkg::coord_t      pix_x,
	output frame_bus_pkg::coord_t      pix_y,
	output logic                       solve_start,
	output logic                       bus_write,
	output frame_bus_pkg::bus_addr_t   bus_addr,
	output logic [31:0]                bus_write_data,
	output logic                       frame_done
);

	// shared counter for the pause and the frame idle wait
	localparam int WAIT_W = $clog2(`IDLE_CYCLES);

	frame_bus_pkg::scan_state_t state;
	logic [WAIT_W-1:0] wait_cnt;
	frame_bus_pkg::bus_addr_t pixel_addr;
	logic last_pixel;

	// base + x + y * row stride
	assign pixel_addr = VRAM_BASE + frame_bus_pkg::bus_addr_t'(pix_x)
		+ (frame_bus_pkg::bus_addr_t'(pix_y) << `ADDR_ROW_SHIFT);

	assign last_pixel = (pix_x == frame_bus_pkg::coord_t'(H_RES - 1))
		&& (pix_y == frame_bus_pkg::coord_t'(V_RES - 1));

	// solver kick, one cycle per pixel
	assign solve_start = (state == frame_bus_pkg::SOLVE_START);

	// ==================================================
	// scan FSM
	// ==================================================
	always_ff @(posedge iCLK or negedge arst_n) begin
		if (!arst_n) begin
			state      <= frame_bus_pkg::IDLE_INIT;
			pix_x      <= '0;
			pix_y      <= '0;
			wait_cnt   <= '0;
			bus_write  <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			case (state)
				// new frame from the top left corner
				frame_bus_pkg::IDLE_INIT: begin
					pix_x <= '0;
					pix_y <= '0;
					state <= frame_bus_pkg::SOLVE_START;
				end
				frame_bus_pkg::SOLVE_START:
					state <= frame_bus_pkg::SOLVE_WAIT;
				// colour is valid with solve_done, raise the write
				frame_bus_pkg::SOLVE_WAIT:
					if (solve_done) begin
						bus_write <= 1'b1;
						state     <= frame_bus_pkg::WRITE;
					end
				// hold the write until the bus takes it
				frame_bus_pkg::WRITE, frame_bus_pkg::WRITE_ACK:
					if (bus_ack) begin
						bus_write <= 1'b0;
						wait_cnt  <= '0;
						if (last_pixel) begin
							frame_done <= 1'b1;
							state      <= frame_bus_pkg::FRAME_IDLE;
						end else begin
							state <= frame_bus_pkg::PAUSE;
						end
					end else begin
						state <= frame_bus_pkg::WRITE_ACK;
					end
				// pause_len + 1 cycles, then step in raster order
				frame_bus_pkg::PAUSE:
					if (wait_cnt == WAIT_W'(pause_len)) begin
						if (pix_x == frame_bus_pkg::coord_t'(H_RES - 1)) begin
							pix_x <= '0;
							pix_y <= pix_y + frame_bus_pkg::coord_t'(1);
						end else begin
							pix_x <= pix_x + frame_bus_pkg::coord_t'(1);
						end
						state <= frame_bus_pkg::SOLVE_START;
					end else begin
						wait_cnt <= wait_cnt + WAIT_W'(1);
					end
				// frame finished, stay quiet before restarting
				frame_bus_pkg::FRAME_IDLE:
					if (wait_cnt == WAIT_W'(`IDLE_CYCLES - 1))
						state <= frame_bus_pkg::IDLE_INIT;
					else
						wait_cnt <= wait_cnt + WAIT_W'(1);
				default:
					state <= frame_bus_pkg::IDLE_INIT;
			endcase
		end
	end

	// bus payload, captured together with the rise of bus_write
	always_ff @(posedge iCLK) begin
		if (state == frame_bus_pkg::SOLVE_WAIT && solve_done) begin
			bus_addr       <= pixel_addr;
			bus_write_data <= {24'b0, pixel_color};
		end
	end

endmodule

`default_nettype wire

// ==== source/iter_palette.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mandel_defs.svh"

module iter_palette #(
	parameter int unsigned MAX_ITER = `MAX_ITER_DEFAULT
) (
	input  wire fixed_math_pkg::iter_t iter_count,
	output frame_bus_pkg::color_t      pixel_color
);

	// position of the leading one, 0 for a zero count
	logic [3:0] msb;
	// count padded below so short counts zero-fill
	logic [`ITER_W+4:0] ext;
	logic [2:0] band;
	logic [4:0] frac;

	always_comb begin
		msb = '0;
		for (int i = 0; i < `ITER_W; i++)
			if (iter_count[i])
				msb = 4'(i);
	end

	// log band in the top bits, five bits under the leading one below
	assign ext  = {iter_count, 5'b0};
	assign band = (msb > 4'd7) ? 3'd7 : msb[2:0];
	assign frac = ext[msb +: 5];

	// never escaped means inside the set, black
	assign pixel_color = (iter_count == fixed_math_pkg::iter_t'(MAX_ITER)) ? '0 : {band, frac};

endmodule

`default_nettype wire

// ==== source/mandel_defs.svh ====
`ifndef MANDEL_DEFS_SVH
`define MANDEL_DEFS_SVH

// fixed point word, signed 4.23
`define FIX_W 27
`define FIX_FRAC 23

// iteration counter and default limit
`define ITER_W 13
`define MAX_ITER_DEFAULT 1000

// frame geometry and video memory layout
`define H_RES_DEFAULT 640
`define V_RES_DEFAULT 480
`define COORD_W 10
`define ADDR_ROW_SHIFT 10

// quiet time after the last pixel of a frame
`define IDLE_CYCLES 256

// |z|^2 bound, 4.0
`define ESCAPE_LIMIT 27'sh2000000
// c at pixel (0,0), -2.0 and -1.0
`define X_ORIGIN_DEFAULT (-27'sd16777216)
`define Y_ORIGIN_DEFAULT (-27'sd8388608)
// about 3/640 between neighbours
`define STEP_DEFAULT 27'sd39322

`endif

// ==== source/mandel_render_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mandel_defs.svh"

module mandel_render_top #(
	parameter int                       H_RES     = `H_RES_DEFAULT,
	parameter int                       V_RES     = `V_RES_DEFAULT,
	parameter int unsigned              MAX_ITER  = `MAX_ITER_DEFAULT,
	parameter fixed_math_pkg::fix_t     X_ORIGIN  = `X_ORIGIN_DEFAULT,
	parameter fixed_math_pkg::fix_t     Y_ORIGIN  = `Y_ORIGIN_DEFAULT,
	parameter fixed_math_pkg::fix_t     STEP      = `STEP_DEFAULT,
	parameter frame_bus_pkg::bus_addr_t VRAM_BASE = 32'h0000_0000
) (
	input  wire logic                iCLK,
	input  wire logic                arst_n,
	input  wire logic [3:0]          zoom,
	input  wire logic [3:0]          pause_len,
	input  wire logic                bus_ack,
	output logic                     bus_write,
	output frame_bus_pkg::bus_addr_t bus_addr,
	output logic [31:0]              bus_write_data,
	output logic                     frame_done
);

	// ==================================================
	// scan -> map -> solve -> colour -> back to scan
	// ==================================================
	frame_bus_pkg::coord_t pix_x, pix_y;
	fixed_math_pkg::fix_t  c_re, c_im;
	fixed_math_pkg::iter_t iter_count;
	frame_bus_pkg::color_t pixel_color;
	logic solve_start, solve_done;

	frame_scanner #(.H_RES(H_RES), .V_RES(V_RES), .VRAM_BASE(VRAM_BASE)) u_scanner (
		.iCLK(iCLK), .arst_n(arst_n), .pause_len(pause_len),
		.solve_done(solve_done), .pixel_color(pixel_color), .bus_ack(bus_ack),
		.pix_x(pix_x), .pix_y(pix_y), .solve_start(solve_start),
		.bus_write(bus_write), .bus_addr(bus_addr),
		.bus_write_data(bus_write_data), .frame_done(frame_done)
	);

	pixel_mapper #(.X_ORIGIN(X_ORIGIN), .Y_ORIGIN(Y_ORIGIN), .STEP(STEP)) u_mapper (
		.zoom(zoom), .pix_x(pix_x), .pix_y(pix_y), .c_re(c_re), .c_im(c_im)
	);

	// one pixel in flight, solver idles between starts
	escape_solver #(.MAX_ITER(MAX_ITER)) u_solver (
		.iCLK(iCLK), .arst_n(arst_n), .solve_start(solve_start),
		.c_re(c_re), .c_im(c_im), .iter_count(iter_count), .solve_done(solve_done)
	);

	iter_palette #(.MAX_ITER(MAX_ITER)) u_palette (
		.iter_count(iter_count), .pixel_color(pixel_color)
	);

endmodule

`default_nettype wire

// ==== source/pixel_mapper.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mandel_defs.svh"

module pixel_mapper #(
	parameter fixed_math_pkg::fix_t X_ORIGIN = `X_ORIGIN_DEFAULT,
	parameter fixed_math_pkg::fix_t Y_ORIGIN = `Y_ORIGIN_DEFAULT,
	parameter fixed_math_pkg::fix_t STEP     = `STEP_DEFAULT
) (
	input  wire logic [3:0]            zoom,
	input  wire frame_bus_pkg::coord_t pix_x,
	input  wire frame_bus_pkg::coord_t pix_y,
	output fixed_math_pkg::fix_t       c_re,
	output fixed_math_pkg::fix_t       c_im
);

	// origin plus coord steps, integer times fixed point
	// no rounding, product wraps to the word width
	function automatic fixed_math_pkg::fix_t axis_point(
		input fixed_math_pkg::fix_t  origin,
		input frame_bus_pkg::coord_t coord,
		input fixed_math_pkg::fix_t  step
	);
		fixed_math_pkg::fix_t coord_fix;
		coord_fix = {{(`FIX_W - `COORD_W){1'b0}}, coord};
		return origin + coord_fix * step;
	endfunction

	// each zoom level halves the spacing
	fixed_math_pkg::fix_t step_z;
	assign step_z = STEP >>> zoom;

	assign c_re = axis_point(X_ORIGIN, pix_x, step_z);
	assign c_im = axis_point(Y_ORIGIN, pix_y, step_z);

endmodule

`default_nettype wire

// ==== tb/mandel_render_assert.sv ====
`timescale 1ns/100ps
`default_nettype none

module mandel_render_assert (
	input wire logic                     iCLK,
	input wire logic                     arst_n,
	input wire logic                     bus_write,
	input wire logic                     bus_ack,
	input wire frame_bus_pkg::bus_addr_t bus_addr,
	input wire logic [31:0]              bus_write_data,
	input wire logic                     solve_start,
	input wire logic                     frame_done
);

	// read back by the testbench at the end
	int unsigned fail_count = 0;

	// ==================================================
	// bus and strobe rules
	// ==================================================

	// write held with a stable payload until acknowledged
	a_write_hold: assert property (@(posedge iCLK) disable iff (!arst_n)
		bus_write && !bus_ack |=> bus_write && $stable(bus_addr) && $stable(bus_write_data))
		else begin
			$error("bus_write dropped or payload moved before acknowledge");
			fail_count++;
		end

	// single cycle pulses
	a_start_pulse: assert property (@(posedge iCLK) disable iff (!arst_n)
		solve_start |=> !solve_start)
		else begin
			$error("solve_start high for more than one cycle");
			fail_count++;
		end

	a_done_pulse: assert property (@(posedge iCLK) disable iff (!arst_n)
		frame_done |=> !frame_done)
		else begin
			$error("frame_done high for more than one cycle");
			fail_count++;
		end

	// bus quiet while in reset
	a_reset_quiet: assert property (@(posedge iCLK) !arst_n |-> !bus_write)
		else begin
			$error("bus_write high during reset");
			fail_count++;
		end

endmodule

bind mandel_render_top mandel_render_assert u_assert (
	.iCLK(iCLK),
	.arst_n(arst_n),
	.bus_write(bus_write),
	.bus_ack(bus_ack),
	.bus_addr(bus_addr),
	.bus_write_data(bus_write_data),
	.solve_start(solve_start),
	.frame_done(frame_done)
);

`default_nettype wire

// ==== tb/mandel_render_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mandel_defs.svh"

module mandel_render_tb;

	// ==================================================
	// setup
	// ==================================================
	localparam int H_RES_TB     = 16;
	localparam int V_RES_TB     = 12;
	localparam int MAX_ITER_TB  = 64;
	localparam int NFRAMES      = 3;
	localparam int RESET_CYCLES = 10;
	// c spans -2..1 across the 16 columns in steps of 3/16
	localparam fixed_math_pkg::fix_t X_ORIGIN_TB = -27'sd16777216;
	localparam fixed_math_pkg::fix_t Y_ORIGIN_TB = -27'sd8388608;
	localparam fixed_math_pkg::fix_t STEP_TB     = 27'sd1572864;
	localparam frame_bus_pkg::bus_addr_t VRAM_BASE_TB = 32'h0004_0000;
	// per pixel solve time plus pause, ack delay and overhead
	localparam int LIMIT = NFRAMES * H_RES_TB * V_RES_TB * (MAX_ITER_TB + 16 + 6 + 8)
		+ NFRAMES * `IDLE_CYCLES + RESET_CYCLES;

	logic iCLK, arst_n, bus_ack, bus_write, frame_done;
	logic [3:0] zoom, pause_len;
	frame_bus_pkg::bus_addr_t bus_addr;
	logic [31:0] bus_write_data;

	// bookkeeping shared by the comparing process and the main flow
	int cycle = 0;
	int checks = 0;
	int errs [5] = '{0, 0, 0, 0, 0};
	string test_name [5] = '{"addresses", "colours", "zoom", "backpressure_pause",
		"frame_restart"};
	int idx = 0;
	int frames_seen = 0;
	int last_ack_cyc = 0;
	int rise_cyc;
	int ack_delay;
	int total;
	int assert_fails;
	logic prev_write = 1'b0;
	frame_bus_pkg::bus_addr_t exp_addr;
	logic [31:0] exp_data;

	mandel_render_top #(
		.H_RES(H_RES_TB), .V_RES(V_RES_TB), .MAX_ITER(MAX_ITER_TB),
		.X_ORIGIN(X_ORIGIN_TB), .Y_ORIGIN(Y_ORIGIN_TB), .STEP(STEP_TB),
		.VRAM_BASE(VRAM_BASE_TB)
	) uut (
		.iCLK(iCLK), .arst_n(arst_n), .zoom(zoom), .pause_len(pause_len),
		.bus_ack(bus_ack), .bus_write(bus_write), .bus_addr(bus_addr),
		.bus_write_data(bus_write_data), .frame_done(frame_done)
	);

	// 20 ns clock
	initial begin
		iCLK = 1'b0;
		forever #10 iCLK = ~iCLK;
	end

	always @(posedge iCLK) cycle <= cycle + 1;

	// hard stop if the frames never complete
	initial begin
		wait (cycle >= LIMIT);
		$display("timeout: run did not finish within %0d cycles", LIMIT);
		$display("TEST FAIL");
		$finish;
	end

	// ==================================================
	// bus slave acks each write after 0..5 cycles
	// ==================================================
	initial begin
		void'($urandom(32'h58363e5e));
		bus_ack = 1'b0;
		forever begin
			@(posedge iCLK);
			#2;
			if (bus_write) begin
				ack_delay = $urandom % 6;
				repeat (ack_delay) begin
					@(posedge iCLK);
					#2;
				end
				bus_ack = 1'b1;
				@(posedge iCLK);
				#2;
				bus_ack = 1'b0;
			end
		end
	end

	// per frame settings
	function automatic int zoom_of(input int f);
		return (f == 1) ? 2 : 0;
	endfunction

	function automatic int pause_of(input int f);
		return (f == 2) ? 15 : 0;
	endfunction

	// which test an error in a given frame belongs to
	function automatic int test_of(input int f, input bit colour);
		if (f == 0)
			return colour ? 1 : 0;
		if (f == 1)
			return 2;
		return 3;
	endfunction

	// keep only the low FIX_W bits as a signed value
	function automatic longint wrap_fix(input longint v);
		logic signed [`FIX_W-1:0] t;
		t = v[`FIX_W-1:0];
		return longint'(t);
	endfunction

	// ==================================================
	// reference model for pixel -> c -> count -> colour
	// ==================================================
	function automatic logic [7:0] expected_color(input int x, input int y, input int zm);
		longint step, cr, ci, zr, zi, sr, si, sx;
		int n, msb, b, band, frac;
		bit done;
		step = longint'(STEP_TB) >>> zm;
		cr = wrap_fix(longint'(X_ORIGIN_TB) + x * step);
		ci = wrap_fix(longint'(Y_ORIGIN_TB) + y * step);
		zr = 0;
		zi = 0;
		n = 0;
		done = 1'b0;
		while (!done) begin
			sr = (zr * zr) >>> `FIX_FRAC;
			si = (zi * zi) >>> `FIX_FRAC;
			sx = (zr * zi) >>> `FIX_FRAC;
			// escaped at |z|^2 >= 4 or ran out of iterations
			if (sr + si >= (longint'(4) <<< `FIX_FRAC) || n == MAX_ITER_TB) begin
				done = 1'b1;
			end else begin
				zr = wrap_fix(sr - si + cr);
				zi = wrap_fix(2 * sx + ci);
				n++;
			end
		end
		if (n == MAX_ITER_TB)
			return 8'h00;
		msb = 0;
		for (b = 0; b < `ITER_W; b++)
			if ((n >> b) != 0)
				msb = b;
		band = (msb > 7) ? 7 : msb;
		frac = ((n << 5) >> msb) & 31;
		return {band[2:0], frac[4:0]};
	endfunction

	task automatic value_error(input int t, input string sig, input logic [31:0] exp_v,
		input logic [31:0] got_v);
		$display("** Error at %0d ns: %s expected %h, got %h", $time, sig, exp_v, got_v);
		errs[t]++;
	endtask

	task automatic plain_error(input int t, input string msg);
		$display("** Error at %0d ns: %s", $time, msg);
		errs[t]++;
	endtask

	task automatic report_test(input int t);
		$display("test %-18s %s (%0d errors)", test_name[t], (errs[t] == 0) ? "ok" : "failed",
			errs[t]);
	endtask

	// ==================================================
	// comparing process sampled at the rising edge
	// ==================================================
	always @(posedge iCLK) begin
		if (arst_n) begin
			// a rise seen now happened one edge earlier
			if (bus_write && !prev_write) begin
				rise_cyc = cycle - 1;
				checks++;
				if (idx == 0 && frames_seen > 0) begin
					if (rise_cyc - last_ack_cyc < `IDLE_CYCLES)
						plain_error(4, "new frame started before the idle wait ended");
				end else if (idx > 0) begin
					if (rise_cyc - last_ack_cyc < pause_of(frames_seen) + 1)
						plain_error(test_of(frames_seen, 1'b0), "write raised inside the pause");
				end
			end
			// accepted write against raster order and reference colour
			if (bus_write && bus_ack) begin
				exp_addr = VRAM_BASE_TB + 32'(idx % H_RES_TB) + (32'(idx / H_RES_TB) << 10);
				exp_data = {24'b0, expected_color(idx % H_RES_TB, idx / H_RES_TB,
					zoom_of(frames_seen))};
				checks += 2;
				if (bus_addr !== exp_addr)
					value_error(test_of(frames_seen, 1'b0), "bus_addr", exp_addr, bus_addr);
				if (bus_write_data !== exp_data)
					value_error(test_of(frames_seen, 1'b1), "bus_write_data", exp_data,
						bus_write_data);
				idx++;
				last_ack_cyc = cycle;
			end
			// end of frame right after the last acknowledge
			if (frame_done) begin
				checks++;
				if (idx != H_RES_TB * V_RES_TB)
					value_error(4, "pixel count at frame_done", H_RES_TB * V_RES_TB, idx);
				if (last_ack_cyc != cycle - 1)
					plain_error(4, "frame_done did not follow the last acknowledge");
				frames_seen++;
				idx = 0;
			end
			prev_write = bus_write;
		end
	end

	// ==================================================
	// main flow
	// ==================================================
	initial begin
		arst_n = 1'b0;
		zoom = 4'd0;
		pause_len = 4'd0;
		repeat (RESET_CYCLES) @(posedge iCLK);
		#2;
		arst_n = 1'b1;
		for (int f = 0; f < NFRAMES; f++) begin
			// scanner idles here so zoom and pause can change
			zoom = 4'(zoom_of(f));
			pause_len = 4'(pause_of(f));
			do begin
				@(posedge iCLK);
				#2;
			end while (frames_seen <= f);
			if (f == 0) begin
				report_test(0);
				report_test(1);
			end else if (f == 1) begin
				report_test(2);
			end else begin
				report_test(3);
				report_test(4);
			end
		end
		total = 0;
		for (int t = 0; t < 5; t++)
			total += errs[t];
		assert_fails = uut.u_assert.fail_count;
		$display("checks %0d, errors %0d, assertion failures %0d", checks, total, assert_fails);
		if (total == 0 && assert_fails == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+source
source/fixed_math_pkg.sv
source/frame_bus_pkg.sv
source/pixel_mapper.sv
source/escape_solver.sv
source/iter_palette.sv
source/frame_scanner.sv
source/mandel_render_top.sv
tb/mandel_render_assert.sv
tb/mandel_render_tb.sv
